// ==== project.f ====
+incdir+include
source/mem_bus_pkg.sv
source/sram_pkg.sv
source/mem_arbiter.sv
source/sram_ctrl.sv
source/mem_subsystem.sv
verif/sram_model.sv
verif/mem_subsystem_sva.sv
verif/mem_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mem_subsystem_tb -f project.f -o sim

output=$(./obj_dir/sim 2>&1)
echo "$output"

if echo "$output" | grep -q "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi

// ==== verif/mem_subsystem_tb.sv ====
`default_nettype none

`include "mem_macros.svh"

module mem_subsystem_tb;

  import mem_bus_pkg::*;
  import sram_pkg::*;

  localparam int timeout_cycles = 20000;

  logic       clock;
  logic       reset;
  logic       fetch_valid;
  bus_addr_t  fetch_addr;
  logic       data_valid;
  bus_addr_t  data_addr;
  bus_data_t  data_wdata;
  bus_strb_t  data_wstrb;
  wire bus_data_t  fetch_rdata;
  wire logic       fetch_ready;
  wire bus_data_t  data_rdata;
  wire logic       data_ready;
  wire sram_addr_t sram_a;
  wire logic       sram_lb_n;
  wire logic       sram_ub_n;
  wire logic       sram_ce_n;
  wire logic       sram_oe_n;
  wire logic       sram_we_n;
  wire sram_data_t sram_dq;

  // byte image of the SRAM, indexed by the aliased byte address
  logic [7:0]  ref_mem [0:(1 << (`SRAM_ADDR_WIDTH + 1))-1];
  logic [31:0] rng = 32'h81b86cfc;
  int          errors = 0;
  int          cycles = 0;
  int          write_cycles = 0;
  bus_addr_t   word_addrs [64];

  mem_subsystem dut (.*);

  sram_model u_sram (
    .clock (clock), .a (sram_a), .lb_n (sram_lb_n), .ub_n (sram_ub_n),
    .ce_n (sram_ce_n), .oe_n (sram_oe_n), .we_n (sram_we_n), .dq (sram_dq)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: a port never answered within %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // SRAM write pin cycles, to catch a request issued twice
  always @(negedge clock) begin
    if (!reset && !sram_ce_n && !sram_we_n) begin
      write_cycles++;
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic void report_mismatch(input string what, input logic [31:0] got,
                                          input logic [31:0] exp);
    errors++;
    $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
  endfunction

  // lanes in priority order: word, low half, high half, lowest single byte
  task automatic ref_write(input bus_addr_t addr, input bus_data_t data,
                           input bus_strb_t strb);
    logic [`SRAM_ADDR_WIDTH:0] base;
    logic [3:0]                lanes;
    base = {addr[`SRAM_ADDR_WIDTH:2], 2'b00};
    if (&strb) lanes = 4'b1111;
    else if (&strb[1:0]) lanes = 4'b0011;
    else if (&strb[3:2]) lanes = 4'b1100;
    else if (strb[0]) lanes = 4'b0001;
    else if (strb[1]) lanes = 4'b0010;
    else if (strb[2]) lanes = 4'b0100;
    else lanes = {strb[3], 3'b000};
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) ref_mem[base + i] = data[8*i +: 8];
    end
  endtask

  function automatic bus_data_t ref_read(input bus_addr_t addr);
    logic [`SRAM_ADDR_WIDTH:0] base;
    base = {addr[`SRAM_ADDR_WIDTH:2], 2'b00};
    return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
  endfunction

  // valid stays high on return, the caller drops it or drives the next request
  task automatic data_access(input bus_addr_t addr, input bus_data_t wdata,
                             input bus_strb_t strb, output bus_data_t rdata,
                             output int lat);
    data_valid = 1'b1;
    data_addr  = addr;
    data_wdata = wdata;
    data_wstrb = strb;
    lat = 0;
    do begin
      @(posedge clock);
      #1;
      lat++;
    end while (!data_ready);
    rdata = data_rdata;
    @(posedge clock);
    #1;
  endtask

  task automatic fetch_access(input bus_addr_t addr, output bus_data_t rdata,
                              output int lat);
    fetch_valid = 1'b1;
    fetch_addr  = addr;
    lat = 0;
    do begin
      @(posedge clock);
      #1;
      lat++;
    end while (!fetch_ready);
    rdata = fetch_rdata;
    @(posedge clock);
    #1;
  endtask

  task automatic check_reset_state();
    if (fetch_ready !== 1'b0 || data_ready !== 1'b0) begin
      errors++;
      $display("Fail at %0t: a port ready is high after reset", $time);
    end
    if (sram_ce_n !== 1'b1 || sram_oe_n !== 1'b1 || sram_we_n !== 1'b1 ||
        sram_lb_n !== 1'b1 || sram_ub_n !== 1'b1) begin
      errors++;
      $display("Fail at %0t: an SRAM enable is active after reset", $time);
    end
  endtask

  task automatic word_traffic();
    bus_data_t wd;
    bus_data_t rd;
    int        lat;
    for (int i = 0; i < 64; i++) begin
      word_addrs[i] = next_rand() & ~32'h3;
      wd = next_rand();
      ref_write(word_addrs[i], wd, 4'hf);
      data_access(word_addrs[i], wd, 4'hf, rd, lat);
      if (lat != 2) report_mismatch("word write latency", lat, 2);
    end
    for (int i = 0; i < 64; i++) begin
      data_access(word_addrs[i], '0, '0, rd, lat);
      if (rd !== ref_read(word_addrs[i])) begin
        report_mismatch("word read data", rd, ref_read(word_addrs[i]));
      end
      if (lat != 2) report_mismatch("word read latency", lat, 2);
    end
    data_valid = 1'b0;
  endtask

  task automatic byte_lanes();
    bus_strb_t pats [6] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100};
    bus_addr_t addr;
    bus_data_t wd;
    bus_data_t rd;
    int        lat;
    addr = next_rand() & ~32'h3;
    wd = next_rand();
    ref_write(addr, wd, 4'hf);
    data_access(addr, wd, 4'hf, rd, lat);
    for (int p = 0; p < 6; p++) begin
      wd = next_rand();
      // the upper address bits alias onto the same word
      ref_write(addr + (p << 20), wd, pats[p]);
      data_access(addr + (p << 20), wd, pats[p], rd, lat);
      if (lat != 1) report_mismatch("sub-word write latency", lat, 1);
      // read back after every pattern so a later write cannot mask a wrong lane
      data_access(addr, '0, '0, rd, lat);
      if (rd !== ref_read(addr)) begin
        report_mismatch("merged byte lanes", rd, ref_read(addr));
      end
    end
    data_valid = 1'b0;
  endtask

  task automatic fetch_path();
    bus_data_t rd;
    int        lat;
    for (int i = 0; i < 16; i++) begin
      fetch_access(word_addrs[i], rd, lat);
      if (rd !== ref_read(word_addrs[i])) begin
        report_mismatch("fetch read data", rd, ref_read(word_addrs[i]));
      end
      if (lat != 2) report_mismatch("fetch latency", lat, 2);
    end
    fetch_valid = 1'b0;
  endtask

  task automatic contention();
    bus_addr_t fbase = 32'h0001_0000;
    bus_addr_t dbase = 32'h0002_0000;
    bus_data_t wd;
    bus_data_t rd;
    bus_data_t frd;
    int        lat;
    int        flat;
    int        dlat;
    int        max_f = 0;
    int        max_d = 0;
    for (int i = 0; i < 32; i++) begin
      wd = next_rand();
      ref_write(fbase + 4*i, wd, 4'hf);
      data_access(fbase + 4*i, wd, 4'hf, rd, lat);
    end
    data_valid = 1'b0;
    fork
      begin
        for (int i = 0; i < 32; i++) begin
          fetch_access(fbase + 4*i, frd, flat);
          if (frd !== ref_read(fbase + 4*i)) begin
            report_mismatch("fetch data under contention", frd, ref_read(fbase + 4*i));
          end
          if (flat > max_f) max_f = flat;
        end
        fetch_valid = 1'b0;
      end
      begin
        for (int i = 0; i < 32; i++) begin
          wd = next_rand();
          ref_write(dbase + 4*i, wd, 4'hf);
          data_access(dbase + 4*i, wd, 4'hf, rd, dlat);
          if (dlat > max_d) max_d = dlat;
        end
        data_valid = 1'b0;
      end
    join
    // one foreign word transfer plus its ready cycle at most
    if (max_f > 5) begin
      errors++;
      $display("Fail at %0t: fetch port waited %0d cycles, more than one data transfer",
               $time, max_f);
    end
    if (max_d > 5) begin
      errors++;
      $display("Fail at %0t: data port waited %0d cycles, more than one fetch transfer",
               $time, max_d);
    end
    for (int i = 0; i < 32; i++) begin
      data_access(dbase + 4*i, '0, '0, rd, lat);
      if (rd !== ref_read(dbase + 4*i)) begin
        report_mismatch("data write under contention", rd, ref_read(dbase + 4*i));
      end
    end
    data_valid = 1'b0;
  endtask

  task automatic no_reissue();
    bus_strb_t pats [6] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100};
    bus_addr_t addr;
    bus_data_t wd;
    bus_strb_t strb;
    bus_data_t rd;
    int        lat;
    int        start;
    addr = next_rand() & ~32'h3;
    start = write_cycles;
    wd = next_rand();
    ref_write(addr, wd, 4'hf);
    data_access(addr, wd, 4'hf, rd, lat);
    for (int i = 0; i < 8; i++) begin
      wd = next_rand();
      strb = pats[next_rand() % 6];
      ref_write(addr + (i << 19), wd, strb);
      data_access(addr + (i << 19), wd, strb, rd, lat);
    end
    data_valid = 1'b0;
    if (write_cycles - start != 10) begin
      report_mismatch("sram write cycles", write_cycles - start, 10);
    end
    data_access(addr, '0, '0, rd, lat);
    data_valid = 1'b0;
    if (rd !== ref_read(addr)) begin
      report_mismatch("back-to-back sub-word result", rd, ref_read(addr));
    end
  endtask

  initial begin
    reset       = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    data_valid  = 1'b0;
    data_addr   = '0;
    data_wdata  = '0;
    data_wstrb  = '0;
    for (int i = 0; i < (1 << (`SRAM_ADDR_WIDTH + 1)); i++) begin
      ref_mem[i] = '0;
    end
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    check_reset_state();
    word_traffic();
    byte_lanes();
    fetch_path();
    contention();
    no_reissue();
    repeat (2) @(posedge clock);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/mem_subsystem_sva.sv ====
`default_nettype none

module mem_subsystem_sva (
  input wire logic clock,
  input wire logic reset,
  input wire logic fetch_valid,
  input wire logic fetch_ready,
  input wire logic data_valid,
  input wire logic data_ready,
  input wire logic sram_ce_n,
  input wire logic sram_oe_n,
  input wire logic sram_we_n
);

  // never read and write the SRAM in the same cycle
  a_oe_we_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(!sram_oe_n && !sram_we_n)) else $error("sram oe and we active together");

  a_ce_with_access: assert property (@(posedge clock) disable iff (reset)
    (!sram_oe_n || !sram_we_n) |-> !sram_ce_n) else $error("sram access without ce");

  a_fetch_ready_pulse: assert property (@(posedge clock) disable iff (reset)
    fetch_ready |=> !fetch_ready) else $error("fetch_ready longer than one cycle");

  a_data_ready_pulse: assert property (@(posedge clock) disable iff (reset)
    data_ready |=> !data_ready) else $error("data_ready longer than one cycle");

  a_fetch_ready_valid: assert property (@(posedge clock) disable iff (reset)
    fetch_ready |-> fetch_valid) else $error("fetch_ready without fetch_valid");

  a_data_ready_valid: assert property (@(posedge clock) disable iff (reset)
    data_ready |-> data_valid) else $error("data_ready without data_valid");

endmodule

bind mem_subsystem mem_subsystem_sva u_sva (
  .clock       (clock),
  .reset       (reset),
  .fetch_valid (fetch_valid),
  .fetch_ready (fetch_ready),
  .data_valid  (data_valid),
  .data_ready  (data_ready),
  .sram_ce_n   (sram_ce_n),
  .sram_oe_n   (sram_oe_n),
  .sram_we_n   (sram_we_n)
);

`default_nettype wire

// ==== verif/sram_model.sv ====
`default_nettype none

`include "mem_macros.svh"

module sram_model (
  input  wire logic                 clock,
  input  wire sram_pkg::sram_addr_t a,
  input  wire logic                 lb_n,
  input  wire logic                 ub_n,
  input  wire logic                 ce_n,
  input  wire logic                 oe_n,
  input  wire logic                 we_n,
  inout  wire sram_pkg::sram_data_t dq
);

  import sram_pkg::*;

  sram_data_t mem [0:(1 << `SRAM_ADDR_WIDTH)-1];

  initial begin
    for (int i = 0; i < (1 << `SRAM_ADDR_WIDTH); i++) begin
      mem[i] = '0;
    end
  end

  // asynchronous read while the chip and its outputs are enabled
  assign dq = (!ce_n && !oe_n && we_n) ? mem[a] : 'z;

  always @(posedge clock) begin
    if (!ce_n && !we_n) begin
      if (!lb_n) begin
        mem[a][7:0] <= dq[7:0];
      end
      if (!ub_n) begin
        mem[a][15:8] <= dq[15:8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/mem_subsystem.sv ====
`default_nettype none

module mem_subsystem (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic                   fetch_valid,
  input  wire mem_bus_pkg::bus_addr_t fetch_addr,
  output wire mem_bus_pkg::bus_data_t fetch_rdata,
  output wire logic                   fetch_ready,
  input  wire logic                   data_valid,
  input  wire mem_bus_pkg::bus_addr_t data_addr,
  input  wire mem_bus_pkg::bus_data_t data_wdata,
  input  wire mem_bus_pkg::bus_strb_t data_wstrb,
  output wire mem_bus_pkg::bus_data_t data_rdata,
  output wire logic                   data_ready,
  output wire sram_pkg::sram_addr_t   sram_a,
  output wire logic                   sram_lb_n,
  output wire logic                   sram_ub_n,
  output wire logic                   sram_ce_n,
  output wire logic                   sram_oe_n,
  output wire logic                   sram_we_n,
  inout  wire sram_pkg::sram_data_t   sram_dq
);

  import mem_bus_pkg::*;

  // shared bus from the arbiter to the controller
  logic      mem_valid;
  bus_addr_t mem_addr;
  bus_data_t mem_wdata;
  bus_strb_t mem_wstrb;
  bus_data_t mem_rdata;
  logic      mem_ready;

  mem_arbiter u_arbiter (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_addr  (fetch_addr),
    .fetch_rdata (fetch_rdata),
    .fetch_ready (fetch_ready),
    .data_valid  (data_valid),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_wstrb  (data_wstrb),
    .data_rdata  (data_rdata),
    .data_ready  (data_ready),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_rdata   (mem_rdata),
    .mem_ready   (mem_ready)
  );

  sram_ctrl u_sram_ctrl (
    .clock     (clock),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .sram_a    (sram_a),
    .sram_lb_n (sram_lb_n),
    .sram_ub_n (sram_ub_n),
    .sram_ce_n (sram_ce_n),
    .sram_oe_n (sram_oe_n),
    .sram_we_n (sram_we_n),
    .sram_dq   (sram_dq)
  );

endmodule

`default_nettype wire

// ==== source/sram_ctrl.sv ====
`default_nettype none

`include "mem_macros.svh"

module sram_ctrl (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic                   mem_valid,
  input  wire mem_bus_pkg::bus_addr_t mem_addr,
  input  wire mem_bus_pkg::bus_data_t mem_wdata,
  input  wire mem_bus_pkg::bus_strb_t mem_wstrb,
  output mem_bus_pkg::bus_data_t      mem_rdata,
  output logic                        mem_ready,
  output sram_pkg::sram_addr_t        sram_a,
  output logic                        sram_lb_n,
  output logic                        sram_ub_n,
  output logic                        sram_ce_n,
  output logic                        sram_oe_n,
  output logic                        sram_we_n,
  inout  wire sram_pkg::sram_data_t   sram_dq
);

  import mem_bus_pkg::*;
  import sram_pkg::*;

  // first pin cycle of a request, in strobe priority order
  function automatic void decode(
    input  bus_addr_t  addr,
    input  bus_data_t  data,
    input  bus_strb_t  strb,
    output sram_addr_t a,
    output sram_data_t dq,
    output logic       lb,
    output logic       ub,
    output logic       wr,
    output logic       two
  );
    sram_addr_t lower;
    sram_addr_t upper;
    lower = {addr[`SRAM_ADDR_WIDTH:2], 1'b0};
    upper = {addr[`SRAM_ADDR_WIDTH:2], 1'b1};
    a   = lower;
    dq  = data[`SRAM_DATA_WIDTH-1:0];
    lb  = 1'b1;
    ub  = 1'b1;
    wr  = 1'b1;
    two = 1'b0;
    if (strb == '0) begin
      wr  = 1'b0;
      two = 1'b1;
    end else if (&strb) begin
      two = 1'b1;
    end else if (&strb[1:0]) begin
      a = lower;
    end else if (&strb[3:2]) begin
      a  = upper;
      dq = data[`MEM_BUS_WIDTH-1:`SRAM_DATA_WIDTH];
    end else if (strb[0]) begin
      ub = 1'b0;
    end else if (strb[1]) begin
      lb = 1'b0;
    end else if (strb[2]) begin
      a  = upper;
      dq = data[`MEM_BUS_WIDTH-1:`SRAM_DATA_WIDTH];
      ub = 1'b0;
    end else begin
      a  = upper;
      dq = data[`MEM_BUS_WIDTH-1:`SRAM_DATA_WIDTH];
      lb = 1'b0;
    end
  endfunction

  sram_state_t state_q;
  sram_state_t state_d;
  sram_addr_t  addr_hi_q;
  sram_addr_t  addr_hi_d;
  sram_data_t  wdata_hi_q;
  sram_data_t  wdata_hi_d;
  logic        rd_q;
  logic        rd_d;
  logic        wr_q;
  logic        wr_d;
  bus_data_t   rdata_q;
  logic        ready_q;
  logic        ready_d;

  sram_addr_t  pin_a;
  sram_data_t  pin_dq;
  logic        pin_lb;
  logic        pin_ub;
  logic        pin_rd;
  logic        pin_wr;
  logic        two_cycle;

  always_comb begin
    state_d    = state_q;
    addr_hi_d  = addr_hi_q;
    wdata_hi_d = wdata_hi_q;
    rd_d       = rd_q;
    wr_d       = wr_q;
    ready_d    = 1'b0;
    pin_a      = '0;
    pin_dq     = '0;
    pin_lb     = 1'b0;
    pin_ub     = 1'b0;
    pin_rd     = 1'b0;
    pin_wr     = 1'b0;
    two_cycle  = 1'b0;
    case (state_q)
      st_idle: begin
        // a valid still held in the ready cycle is the finished request
        if (mem_valid && !ready_q) begin
          decode(mem_addr, mem_wdata, mem_wstrb, pin_a, pin_dq, pin_lb, pin_ub,
                 pin_wr, two_cycle);
          pin_rd = !pin_wr;
          if (two_cycle) begin
            state_d    = st_upper;
            addr_hi_d  = {pin_a[`SRAM_ADDR_WIDTH-1:1], 1'b1};
            wdata_hi_d = mem_wdata[`MEM_BUS_WIDTH-1:`SRAM_DATA_WIDTH];
            rd_d       = pin_rd;
            wr_d       = pin_wr;
          end else begin
            ready_d = 1'b1;
          end
        end
      end
      st_upper: begin
        pin_a   = addr_hi_q;
        pin_dq  = wdata_hi_q;
        pin_lb  = 1'b1;
        pin_ub  = 1'b1;
        pin_rd  = rd_q;
        pin_wr  = wr_q;
        state_d = st_idle;
        ready_d = 1'b1;
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  assign sram_a    = pin_a;
  assign sram_lb_n = ~pin_lb;
  assign sram_ub_n = ~pin_ub;
  assign sram_ce_n = ~(pin_rd | pin_wr);
  assign sram_oe_n = ~pin_rd;
  assign sram_we_n = ~pin_wr;
  assign sram_dq   = pin_wr ? pin_dq : 'z;

  assign mem_rdata = rdata_q;
  assign mem_ready = ready_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= st_idle;
      rd_q    <= 1'b0;
      wr_q    <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      rd_q    <= rd_d;
      wr_q    <= wr_d;
      ready_q <= ready_d;
    end
    addr_hi_q  <= addr_hi_d;
    wdata_hi_q <= wdata_hi_d;
    // each read halfword is taken at the end of its pin cycle
    if (pin_rd) begin
      if (state_q == st_upper) begin
        rdata_q[`MEM_BUS_WIDTH-1:`SRAM_DATA_WIDTH] <= sram_dq;
      end else begin
        rdata_q[`SRAM_DATA_WIDTH-1:0] <= sram_dq;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic                   fetch_valid,
  input  wire mem_bus_pkg::bus_addr_t fetch_addr,
  output mem_bus_pkg::bus_data_t      fetch_rdata,
  output logic                        fetch_ready,
  input  wire logic                   data_valid,
  input  wire mem_bus_pkg::bus_addr_t data_addr,
  input  wire mem_bus_pkg::bus_data_t data_wdata,
  input  wire mem_bus_pkg::bus_strb_t data_wstrb,
  output mem_bus_pkg::bus_data_t      data_rdata,
  output logic                        data_ready,
  output logic                        mem_valid,
  output mem_bus_pkg::bus_addr_t      mem_addr,
  output mem_bus_pkg::bus_data_t      mem_wdata,
  output mem_bus_pkg::bus_strb_t      mem_wstrb,
  input  wire mem_bus_pkg::bus_data_t mem_rdata,
  input  wire logic                   mem_ready
);

  import mem_bus_pkg::*;

  logic   locked_q;
  grant_t grant_q;
  grant_t last_q;
  grant_t pick;
  grant_t grant;
  logic   sel_fetch;

  // alternating priority, the loser of the last tie goes first
  always_comb begin
    if (fetch_valid && data_valid) begin
      pick = (last_q == grant_data) ? grant_fetch : grant_data;
    end else if (fetch_valid) begin
      pick = grant_fetch;
    end else begin
      pick = grant_data;
    end
  end

  // idle grant is combinational so the arbiter adds no cycle
  assign grant     = locked_q ? grant_q : pick;
  assign sel_fetch = (grant == grant_fetch);

  assign mem_valid = sel_fetch ? fetch_valid : data_valid;
  assign mem_addr  = sel_fetch ? fetch_addr : data_addr;
  assign mem_wdata = data_wdata;
  // instruction fetches are always reads
  assign mem_wstrb = sel_fetch ? '0 : data_wstrb;

  assign fetch_rdata = mem_rdata;
  assign data_rdata  = mem_rdata;
  assign fetch_ready = mem_ready && sel_fetch;
  assign data_ready  = mem_ready && !sel_fetch;

  // hold the owner from acceptance until the controller answers
  always_ff @(posedge clock) begin
    if (reset) begin
      locked_q <= 1'b0;
      grant_q  <= grant_fetch;
      last_q   <= grant_data;
    end else if (locked_q) begin
      if (mem_ready) begin
        locked_q <= 1'b0;
      end
    end else if (mem_valid) begin
      locked_q <= 1'b1;
      grant_q  <= pick;
      last_q   <= pick;
    end
  end

endmodule

`default_nettype wire

// ==== source/sram_pkg.sv ====
`default_nettype none

`include "mem_macros.svh"

package sram_pkg;

  // halfword address on the SRAM pins
  typedef logic [`SRAM_ADDR_WIDTH-1:0] sram_addr_t;

  typedef logic [`SRAM_DATA_WIDTH-1:0] sram_data_t;

  // st_upper is the second halfword of a full-word access
  typedef enum logic {
    st_idle,
    st_upper
  } sram_state_t;

endpackage

`default_nettype wire

// ==== source/mem_bus_pkg.sv ====
`default_nettype none

`include "mem_macros.svh"

package mem_bus_pkg;

  // byte address, bits above the SRAM range alias
  typedef logic [`MEM_BUS_WIDTH-1:0] bus_addr_t;

  typedef logic [`MEM_BUS_WIDTH-1:0] bus_data_t;

  // all zero strobes mean a read
  typedef logic [`MEM_STRB_WIDTH-1:0] bus_strb_t;

  // owner of the shared bus
  typedef enum logic {
    grant_fetch,
    grant_data
  } grant_t;

endpackage

`default_nettype wire

// ==== include/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// shared memory bus between the masters and the SRAM controller
`define MEM_BUS_WIDTH 32

// one strobe per byte lane of the bus word
`define MEM_STRB_WIDTH 4

// external asynchronous SRAM, 256K halfwords with two byte lanes
`define SRAM_ADDR_WIDTH 18

`define SRAM_DATA_WIDTH 16

`endif
